//--- build.f
+incdir+include
hdl/aes_bridge_pkg.sv
hdl/byte_fifo.sv
hdl/bus_decoder.sv
hdl/cipher_sequencer.sv
hdl/read_responder.sv
hdl/aes_fifo_bridge.sv
dv/tb_aes_fifo_bridge.sv

//--- Makefile
# Verilator build and run for the AES FIFO bridge testbench

TOP = tb_aes_fifo_bridge

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir

# the log decides pass or fail
run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- dv/tb_aes_fifo_bridge.sv
/*
 * Testbench for the AES FIFO bridge.
 * Loads three blocks of LFSR key and plaintext bytes, polls status for
 * done and reads back the results with random rready back-pressure.
 * Results are checked against key XOR plaintext, with a cycle watchdog.
 */

`timescale 1ns/10ps
`default_nettype none

`include "aes_bridge_params.svh"

module tb_aes_fifo_bridge;
	import aes_bridge_pkg::*;

	localparam int num_blocks  = 3;
	localparam int cycle_limit = num_blocks * 600;  // generous per block

	logic      clk_main_a0;
	logic      rst_main_n_sync;
	bus_addr_t wr_addr;
	logic      wready;
	bus_data_t wdata;
	logic      arvalid_q;
	bus_addr_t araddr_q;
	logic      rready;
	logic      rvalid;
	bus_data_t rdata;

	logic [15:0] lfsr_state = 16'd8;  // seed
	int          error_count = 0;
	int          check_count = 0;
	int          cycle_count = 0;
	byte_t       key_mem [`BLOCK_BYTES];
	bus_data_t   exp_q [$];   // model results in write order
	bus_data_t   got;
	bus_data_t   exp;
	bus_data_t   tmp;
	bus_addr_t   other_addr;
	byte_t       text_b;
	int          hold;

	aes_fifo_bridge u_dut (
		.clk_main_a0     (clk_main_a0),
		.rst_main_n_sync (rst_main_n_sync),
		.wr_addr         (wr_addr),
		.wready          (wready),
		.wdata           (wdata),
		.arvalid_q       (arvalid_q),
		.araddr_q        (araddr_q),
		.rready          (rready),
		.rvalid          (rvalid),
		.rdata           (rdata)
	);

	initial
	begin
		clk_main_a0 = 1'b0;
		forever #10 clk_main_a0 = ~clk_main_a0;  // 20 ns period
	end

	// watchdog
	always @(posedge clk_main_a0)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit)
		begin
			$display("timeout: run passed %0d cycles without finishing", cycle_limit);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// ----------------------------------------
	// random source
	// ----------------------------------------
	function automatic logic next_rand_bit();
		logic lsb;
		lsb = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (lsb)
			lfsr_state = lfsr_state ^ 16'hB400;  // galois taps 16,14,13,11
		return lsb;
	endfunction

	function automatic bus_data_t rand_value(input int nbits);
		bus_data_t v;
		v = '0;
		for (int i = 0; i < nbits; i++)
			v = {v[30:0], next_rand_bit()};  // one step per bit
		return v;
	endfunction

	// ----------------------------------------
	// bus tasks, entered and left on negedge
	// ----------------------------------------
	task automatic write_word(input bus_addr_t addr, input bus_data_t data);
		wr_addr = addr;
		wdata   = data;
		wready  = 1'b1;
		@(negedge clk_main_a0);
		wready  = 1'b0;
	endtask

	task automatic read_word(input bus_addr_t addr, input int hold_cycles,
		output bus_data_t val);
		arvalid_q = 1'b1;
		araddr_q  = addr;
		rready    = 1'b0;
		@(negedge clk_main_a0);
		arvalid_q = 1'b0;  // single request
		while (!rvalid)
			@(negedge clk_main_a0);
		val = rdata;
		repeat (hold_cycles)
		begin
			@(negedge clk_main_a0);
			check_count++;
			assert (rvalid)
			else
			begin
				error_count++;
				$display("rvalid dropped before the rready handshake");
			end
			assert (rdata == val)
			else
			begin
				error_count++;
				$display("[FAIL] rdata changed under back-pressure: 0x%08h, was 0x%08h",
					rdata, val);
			end
		end
		rready = 1'b1;
		@(negedge clk_main_a0);
		rready = 1'b0;
		check_count++;
		assert (!rvalid)
		else
		begin
			error_count++;
			$display("rvalid still high after the rready handshake");
		end
	endtask

	task automatic check_value(input string what, input bus_data_t got_v,
		input bus_data_t exp_v);
		check_count++;
		assert (got_v == exp_v)
		else
		begin
			error_count++;
			$display("[FAIL] rdata %s: got 0x%08h, expected 0x%08h", what, got_v, exp_v);
		end
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial
	begin
		rst_main_n_sync = 1'b0;
		wr_addr         = '0;
		wready          = 1'b0;
		wdata           = '0;
		arvalid_q       = 1'b0;
		araddr_q        = '0;
		rready          = 1'b0;
		repeat (8) @(posedge clk_main_a0);
		@(negedge clk_main_a0);
		rst_main_n_sync = 1'b1;
		@(negedge clk_main_a0);

		for (int b = 0; b < num_blocks; b++)
		begin
			// key bytes, upper wdata bits are noise
			for (int i = 0; i < `BLOCK_BYTES; i++)
			begin
				key_mem[i] = byte_t'(rand_value(8));
				tmp = rand_value(24);
				write_word(`BRIDGE_DATA_ADDR, {tmp[23:0], key_mem[i]});
			end
			tmp = rand_value(8);
			other_addr = 32'h0000_1000 | (tmp << 2);  // outside the bridge map
			write_word(other_addr, rand_value(32));

			// half loaded, nothing ready yet
			read_word(`BRIDGE_STATUS_ADDR, 0, got);
			check_value("status mid-load", got, 32'h0);
			read_word(`BRIDGE_DATA_ADDR, 0, got);
			check_value("data mid-load", got, 32'h0);
			read_word(other_addr, 0, got);
			check_value("other address", got, 32'h0);

			// plaintext bytes and model
			for (int i = 0; i < `BLOCK_BYTES; i++)
			begin
				text_b = byte_t'(rand_value(8));
				tmp = rand_value(24);
				write_word(`BRIDGE_DATA_ADDR, {tmp[23:0], text_b});
				exp_q.push_back({24'h0, key_mem[i] ^ text_b});
				if (i == 7)
					write_word(`BRIDGE_STATUS_ADDR, rand_value(32));  // no effect
			end

			// poll until done, watchdog bounds it
			got = '0;
			while (got[0] !== 1'b1)
				read_word(`BRIDGE_STATUS_ADDR, 0, got);
			check_value("status after load", got, 32'h1);

			// writes while done must be dropped
			repeat (4) write_word(`BRIDGE_DATA_ADDR, rand_value(32));
			read_word(other_addr, 0, got);
			check_value("other address while done", got, 32'h0);

			for (int i = 0; i < `BLOCK_BYTES; i++)
			begin
				hold = int'(rand_value(3) % 6);  // 0 to 5 cycles of back-pressure
				read_word(`BRIDGE_DATA_ADDR, hold, got);
				exp = exp_q.pop_front();
				check_value($sformatf("block %0d byte %0d", b, i), got, exp);
			end

			// drained, back to key collection
			read_word(`BRIDGE_STATUS_ADDR, 0, got);
			check_value("status after drain", got, 32'h0);
		end

		$display("checks %0d, errors %0d, cycles %0d", check_count, error_count, cycle_count);
		if (error_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/aes_fifo_bridge.sv
/*
 * Top of the AES FIFO bridge.
 * Connects the bus decoder, the three byte FIFOs, the cipher
 * sequencer and the read responder. Software loads key and
 * plaintext at the data address and polls status for done.
 */

`timescale 1ns/10ps
`default_nettype none

`include "aes_bridge_params.svh"

module aes_fifo_bridge
(
	input  wire                            clk_main_a0,
	input  wire                            rst_main_n_sync,
	input  wire aes_bridge_pkg::bus_addr_t wr_addr,
	input  wire                            wready,
	input  wire aes_bridge_pkg::bus_data_t wdata,
	input  wire                            arvalid_q,
	input  wire aes_bridge_pkg::bus_addr_t araddr_q,
	input  wire                            rready,
	output logic                           rvalid,
	output aes_bridge_pkg::bus_data_t      rdata
);
	import aes_bridge_pkg::*;

	// ----------------------------------------
	// internal wiring
	// ----------------------------------------
	logic  wr_strobe;
	byte_t wr_byte;
	logic  rd_data_sel;
	logic  rd_status_sel;
	logic  key_push;
	logic  text_push;
	byte_t push_byte;
	logic  in_pop;      // shared pop for key and text
	byte_t key_byte;
	byte_t text_byte;
	logic  key_full;
	logic  key_empty;
	logic  text_full;
	logic  text_empty;
	logic  out_push;
	byte_t out_byte;
	logic  out_full;
	logic  out_empty;
	byte_t res_byte;
	logic  res_pop;
	logic  done;

	bus_decoder u_bus_decoder (
		.clk_main_a0     (clk_main_a0),
		.rst_main_n_sync (rst_main_n_sync),
		.wr_addr         (wr_addr),
		.wready          (wready),
		.wdata           (wdata),
		.araddr_q        (araddr_q),
		.wr_strobe       (wr_strobe),
		.wr_byte         (wr_byte),
		.rd_data_sel     (rd_data_sel),
		.rd_status_sel   (rd_status_sel)
	);

	// ----------------------------------------
	// fifos
	// ----------------------------------------
	byte_fifo #(.depth(`BRIDGE_FIFO_DEPTH)) u_key_fifo (
		.clk_main_a0     (clk_main_a0),
		.rst_main_n_sync (rst_main_n_sync),
		.push            (key_push),
		.din             (push_byte),
		.pop             (in_pop),
		.dout            (key_byte),
		.full            (key_full),
		.empty           (key_empty)
	);

	byte_fifo #(.depth(`BRIDGE_FIFO_DEPTH)) u_text_fifo (
		.clk_main_a0     (clk_main_a0),
		.rst_main_n_sync (rst_main_n_sync),
		.push            (text_push),
		.din             (push_byte),
		.pop             (in_pop),
		.dout            (text_byte),
		.full            (text_full),
		.empty           (text_empty)
	);

	byte_fifo #(.depth(`BRIDGE_FIFO_DEPTH)) u_out_fifo (
		.clk_main_a0     (clk_main_a0),
		.rst_main_n_sync (rst_main_n_sync),
		.push            (out_push),
		.din             (out_byte),
		.pop             (res_pop),
		.dout            (res_byte),
		.full            (out_full),
		.empty           (out_empty)
	);

	// ----------------------------------------
	// control and read channel
	// ----------------------------------------
	cipher_sequencer u_cipher_sequencer (
		.clk_main_a0     (clk_main_a0),
		.rst_main_n_sync (rst_main_n_sync),
		.wr_strobe       (wr_strobe),
		.wr_byte         (wr_byte),
		.key_push        (key_push),
		.text_push       (text_push),
		.push_byte       (push_byte),
		.key_full        (key_full),
		.text_full       (text_full),
		.key_empty       (key_empty),
		.in_pop          (in_pop),
		.key_byte        (key_byte),
		.text_byte       (text_byte),
		.out_push        (out_push),
		.out_byte        (out_byte),
		.out_full        (out_full),
		.out_empty       (out_empty),
		.done            (done)
	);

	read_responder u_read_responder (
		.clk_main_a0     (clk_main_a0),
		.rst_main_n_sync (rst_main_n_sync),
		.arvalid_q       (arvalid_q),
		.rd_data_sel     (rd_data_sel),
		.rd_status_sel   (rd_status_sel),
		.rready          (rready),
		.done            (done),
		.res_byte        (res_byte),
		.res_empty       (out_empty),
		.res_pop         (res_pop),
		.rvalid          (rvalid),
		.rdata           (rdata)
	);

	// sequencer watches key_empty only, text fifo must keep pace
	a_lockstep: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
		key_empty |-> text_empty)
		else $error("aes_fifo_bridge: key and text fifos out of step");

endmodule

`default_nettype wire

//--- hdl/read_responder.sv
/*
 * Read channel of the bridge.
 * Takes one read at a time, returns a result byte or the done flag,
 * and holds rvalid and rdata until the master asserts rready.
 */

`timescale 1ns/10ps
`default_nettype none

module read_responder
(
	input  wire                        clk_main_a0,
	input  wire                        rst_main_n_sync,
	input  wire                        arvalid_q,
	input  wire                        rd_data_sel,
	input  wire                        rd_status_sel,
	input  wire                        rready,
	input  wire                        done,
	input  wire aes_bridge_pkg::byte_t res_byte,
	input  wire                        res_empty,
	output logic                       res_pop,
	output logic                       rvalid,
	output aes_bridge_pkg::bus_data_t  rdata
);
	import aes_bridge_pkg::*;

	bus_data_t rdata_next;
	logic      accept;  // new read taken this cycle

	assign accept  = arvalid_q && !rvalid;  // only while idle
	assign res_pop = accept && rd_data_sel && !res_empty;

	// response word, zero for empty fifo or unknown address
	always_comb
	begin
		rdata_next = '0;
		if (rd_status_sel)
			rdata_next = {31'b0, done};
		else if (rd_data_sel && !res_empty)
			rdata_next = {24'b0, res_byte};
	end

	always_ff @(posedge clk_main_a0)
	begin
		if (!rst_main_n_sync)
			rvalid <= 1'b0;
		else if (accept)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;  // handshake done
	end

	always_ff @(posedge clk_main_a0)
	begin
		if (accept)
			rdata <= rdata_next;
	end

	// back-pressure, response frozen until taken
	a_hold_resp: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
		rvalid && !rready |=> rvalid && $stable(rdata))
		else $error("read_responder: response changed under back-pressure");

endmodule

`default_nettype wire

//--- hdl/cipher_sequencer.sv
/*
 * Control FSM of the bridge.
 * Steers write bytes into the key FIFO, then the plaintext FIFO,
 * pops both in lockstep through the registered AddRoundKey XOR into
 * the output FIFO and raises done until software drains the results.
 */

`timescale 1ns/10ps
`default_nettype none

module cipher_sequencer
(
	input  wire                        clk_main_a0,
	input  wire                        rst_main_n_sync,
	// write byte stream
	input  wire                        wr_strobe,
	input  wire aes_bridge_pkg::byte_t wr_byte,
	// input fifo side
	output logic                       key_push,
	output logic                       text_push,
	output aes_bridge_pkg::byte_t      push_byte,
	input  wire                        key_full,
	input  wire                        text_full,
	input  wire                        key_empty,
	output logic                       in_pop,
	input  wire aes_bridge_pkg::byte_t key_byte,
	input  wire aes_bridge_pkg::byte_t text_byte,
	// output fifo side
	output logic                       out_push,
	output aes_bridge_pkg::byte_t      out_byte,
	input  wire                        out_full,
	input  wire                        out_empty,
	output logic                       done
);
	import aes_bridge_pkg::*;

	seq_state_e state;
	seq_state_e state_next;
	logic       key_phase;   // strobe goes to key fifo
	logic       text_phase;  // strobe goes to text fifo

	// ----------------------------------------
	// write steering
	// ----------------------------------------
	// key_full ends the key phase right away, so a back-to-back
	// write in the transition cycle still lands in the text fifo
	assign key_phase  = (state == collect_key) && !key_full;
	assign text_phase = ((state == collect_key) && key_full) ||
	                    ((state == collect_text) && !text_full);

	assign key_push  = wr_strobe && key_phase;
	assign text_push = wr_strobe && text_phase;
	assign push_byte = wr_byte;  // shared din for both input fifos

	// ----------------------------------------
	// run path
	// ----------------------------------------
	// both fifos hold the same count, key_empty stands for both
	assign in_pop = (state == run_cipher) && !key_empty;

	always_ff @(posedge clk_main_a0)
	begin
		if (in_pop)
			out_byte <= key_byte ^ text_byte;  // addroundkey
	end

	// ----------------------------------------
	// FSM
	// ----------------------------------------
	always_comb
	begin
		state_next = state;
		unique case (state)
			collect_key:
			begin
				if (key_full)
					state_next = collect_text;
			end
			collect_text:
			begin
				if (text_full)
					state_next = run_cipher;
			end
			run_cipher:
			begin
				if (out_full)
					state_next = serve_read;  // all 16 results queued
			end
			serve_read:
			begin
				if (out_empty)
					state_next = collect_key;  // software drained it
			end
			default:
				state_next = collect_key;
		endcase
	end

	always_ff @(posedge clk_main_a0)
	begin
		if (!rst_main_n_sync)
		begin
			state    <= collect_key;
			out_push <= 1'b0;
		end
		else
		begin
			state    <= state_next;
			out_push <= in_pop;  // push lands one cycle after pop
		end
	end

	assign done = (state == serve_read);

	// lockstep pops only while results still fit
	a_pop_in_run: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
		in_pop |-> (state == run_cipher) && !out_full)
		else $error("cipher_sequencer: input pop outside run_cipher");

endmodule

`default_nettype wire

//--- hdl/bus_decoder.sv
/*
 * Address decode for the bridge bus.
 * An accepted write to the data address comes out one cycle later
 * as a single-cycle strobe with the low byte of wdata.
 * The read address is decoded combinationally into two selects.
 */

`timescale 1ns/10ps
`default_nettype none

`include "aes_bridge_params.svh"

module bus_decoder
(
	input  wire                            clk_main_a0,
	input  wire                            rst_main_n_sync,
	input  wire aes_bridge_pkg::bus_addr_t wr_addr,
	input  wire                            wready,
	input  wire aes_bridge_pkg::bus_data_t wdata,
	input  wire aes_bridge_pkg::bus_addr_t araddr_q,
	output logic                           wr_strobe,
	output aes_bridge_pkg::byte_t          wr_byte,
	output logic                           rd_data_sel,
	output logic                           rd_status_sel
);
	logic wr_hit;  // write accepted this cycle

	assign wr_hit = wready && (wr_addr == `BRIDGE_DATA_ADDR);

	always_ff @(posedge clk_main_a0)
	begin
		if (!rst_main_n_sync)
			wr_strobe <= 1'b0;
		else
			wr_strobe <= wr_hit;  // one pulse per accepted write
	end

	always_ff @(posedge clk_main_a0)
	begin
		if (wr_hit)
			wr_byte <= wdata[7:0];  // only low byte carries data
	end

	// read side, no register
	assign rd_data_sel   = (araddr_q == `BRIDGE_DATA_ADDR);
	assign rd_status_sel = (araddr_q == `BRIDGE_STATUS_ADDR);

endmodule

`default_nettype wire

//--- hdl/byte_fifo.sv
/*
 * Synchronous byte FIFO with show-ahead output.
 * dout always carries the head entry, pop just advances past it.
 * Pushes while full and pops while empty are dropped and flagged.
 */

`timescale 1ns/10ps
`default_nettype none

module byte_fifo #(
	parameter int depth = 16
)
(
	input  wire                        clk_main_a0,
	input  wire                        rst_main_n_sync,
	input  wire                        push,
	input  wire aes_bridge_pkg::byte_t din,
	input  wire                        pop,
	output aes_bridge_pkg::byte_t      dout,
	output logic                       full,
	output logic                       empty
);
	import aes_bridge_pkg::*;

	localparam int            aw        = (depth > 1) ? $clog2(depth) : 1;
	localparam logic [aw-1:0] last_idx  = aw'(depth - 1);
	localparam logic [aw:0]   depth_cnt = (aw+1)'(depth);

	byte_t         mem [depth];  // storage, no reset
	logic [aw-1:0] wr_ptr;
	logic [aw-1:0] rd_ptr;
	logic [aw:0]   count;        // occupancy
	logic          do_push;
	logic          do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;
	assign full    = (count == depth_cnt);
	assign empty   = (count == '0);
	assign dout    = mem[rd_ptr];  // head byte, no read latency

	always_ff @(posedge clk_main_a0)
	begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	// pointers wrap at depth, so non power of two also works
	always_ff @(posedge clk_main_a0)
	begin
		if (!rst_main_n_sync)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == last_idx) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == last_idx) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // idle or push+pop together
			endcase
		end
	end

	// caller must respect the flags
	a_no_overflow: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
		!(push && full))
		else $error("byte_fifo: push while full");

	a_no_underflow: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
		!(pop && empty))
		else $error("byte_fifo: pop while empty");

endmodule

`default_nettype wire

//--- hdl/aes_bridge_pkg.sv
/*
 * Shared types for the AES FIFO bridge.
 * Byte and bus vectors plus the sequencer state encoding.
 * Ports name these by scope, module bodies import the package.
 */

`default_nettype none

package aes_bridge_pkg;

	// ----------------------------------------
	// data widths
	// ----------------------------------------
	typedef logic [7:0]  byte_t;      // key, plaintext or result byte
	typedef logic [31:0] bus_addr_t;  // bus address
	typedef logic [31:0] bus_data_t;  // bus data word

	// ----------------------------------------
	// sequencer FSM
	// ----------------------------------------
	typedef enum logic [1:0] {
		collect_key  = 2'd0,  // loading 16 key bytes
		collect_text = 2'd1,  // loading 16 plaintext bytes
		run_cipher   = 2'd2,  // addroundkey into output fifo
		serve_read   = 2'd3   // results waiting for software
	} seq_state_e;

endpackage

`default_nettype wire

//--- include/aes_bridge_params.svh
/*
 * Bus map and sizing for the AES FIFO bridge.
 * Include this in any module or testbench that needs the bridge
 * addresses, the block length or the FIFO depth.
 */

`ifndef AES_BRIDGE_PARAMS_SVH
`define AES_BRIDGE_PARAMS_SVH

// bus addresses
`define BRIDGE_DATA_ADDR     32'h0000_0510  // byte writes, result reads
`define BRIDGE_STATUS_ADDR   32'h0000_0514  // done flag in bit 0

// block sizing
`define BLOCK_BYTES          16  // key or plaintext length in bytes

// every bridge FIFO, never below BLOCK_BYTES
`define BRIDGE_FIFO_DEPTH    16

`endif
